//--- verilog.f
+incdir+hdl
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/controlSequencer.sv
hdl/dataPath.sv
hdl/wbMaster.sv
hdl/cpuCore.sv
sim/clockGen.sv
sim/cpuCore_properties.sv
sim/cpuCore_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/isaPkg.sv
      - hdl/ctrlPkg.sv
      - hdl/instrDecoder.sv
      - hdl/controlSequencer.sv
      - hdl/dataPath.sv
      - hdl/wbMaster.sv
      - hdl/cpuCore.sv
  - target: simulation
    files:
      - sim/clockGen.sv
      - sim/cpuCore_properties.sv
      - sim/cpuCore_tb.sv

//--- sim/cpuCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore_tb;

    localparam int progLen = 43;      // Program words
    localparam int waitLimit = 4;     // Longest ack delay in cycles
    localparam int timeoutCycles = progLen * 40 * (waitLimit + 1);

    logic clk;
    logic rst;
    logic cyc, stb, we, ack, halted;
    isaPkg::addr_t adr;
    isaPkg::word_t datOut;
    isaPkg::word_t datIn;

    isaPkg::word_t mem [0:255];      // Memory seen by the DUT
    isaPkg::word_t initMem [0:255];  // Image before the run, for the model
    isaPkg::addr_t expAddr [$];
    isaPkg::word_t expData [$];
    isaPkg::addr_t obsAddr [$];
    isaPkg::word_t obsData [$];
    isaPkg::addr_t expHaltAddr;
    isaPkg::addr_t lastReadAddr;
    int writeCount;
    int seed;
    int waitCycles;

    clockGen #(.periodNs(8)) clock (.clk(clk));

    cpuCore UUT (.*);

    bind cpuCore cpuCore_properties props (.*);

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic isaPkg::word_t sext8(input logic [7:0] v);
        return isaPkg::word_t'({{8{v[7]}}, v});
    endfunction

    function automatic isaPkg::word_t aTypeWord(input logic [2:0] mode, input logic [3:0] func,
                                                input logic [1:0] src2, input logic [2:0] dst);
        return {4'b0000, mode, func, src2, dst};
    endfunction

    function automatic isaPkg::word_t iTypeWord(input logic [1:0] func, input logic [1:0] rg,
                                                input logic [7:0] imm8);
        return {2'b01, func, 1'b0, rg, 1'b0, imm8};
    endfunction

    function automatic isaPkg::word_t jumpWord(input logic [14:0] off);
        return {1'b1, off};
    endfunction

    function automatic isaPkg::word_t flagWord(input logic set, input logic val,
                                               input logic [1:0] idx, input logic [7:0] off);
        return {4'b0010, set, val, idx, off};
    endfunction

    // ALU as the instruction set defines it, flags updated in place
    function automatic isaPkg::word_t aluRef(input logic [3:0] f, input isaPkg::word_t a,
                                             input isaPkg::word_t b, inout isaPkg::flags_t fl);
        logic [16:0] w;
        isaPkg::word_t y;
        case (f)
            4'd0: w = {1'b0, a} + {1'b0, b};
            4'd1: w = {1'b0, a & b};
            4'd2: w = {1'b0, a} - {1'b0, b};
            4'd3: w = {1'b0, a | b};
            4'd4: w = {1'b0, a ^ b};
            4'd5: w = {1'b0, b};
            default: w = {1'b0, a};
        endcase
        y = w[15:0];
        fl = '0;
        fl[0] = (y == 16'h0000);
        fl[2] = y[15];
        if (f == 4'd0) begin
            fl[1] = w[16];
            fl[3] = (a[15] == b[15]) && (y[15] != a[15]);
        end else if (f == 4'd2) begin
            fl[1] = w[16];
            fl[3] = (a[15] != b[15]) && (y[15] != a[15]);
        end
        return y;
    endfunction

    // Runs the program, fills the expected writes, returns the halting fetch address
    function automatic isaPkg::addr_t runModel();
        isaPkg::word_t m [0:255];
        isaPkg::word_t r [0:3];
        isaPkg::flags_t fl;
        isaPkg::addr_t pc;
        isaPkg::addr_t fetchAddr;
        isaPkg::word_t ir;
        isaPkg::word_t a;
        isaPkg::word_t res;
        logic [2:0] mode;
        logic [2:0] d;
        for (int i = 0; i < 256; i++) m[i] = initMem[i];
        r = '{default: '0};
        fl = '0;
        pc = '0;
        for (int step = 0; step < 1000; step++) begin
            fetchAddr = pc;
            ir = m[pc[7:0]];
            pc = pc + 1'b1;
            if (ir[15]) begin
                pc = pc + {ir[14], ir[14:0]};
            end else if (ir[15:14] == 2'b01) begin
                if (ir[11]) return fetchAddr;
                res = aluRef({2'b00, ir[13:12]}, r[ir[10:9]], sext8(ir[7:0]), fl);
                if (ir[10:9] != 2'd0) r[ir[10:9]] = res;
            end else if (ir[15:12] == 4'b0010) begin
                if (ir[11]) fl[ir[9:8]] = ir[10];
                else if (fl[ir[9:8]] == ir[10]) pc = pc + sext8(ir[7:0]);
            end else if (ir[15:12] == 4'b0000) begin
                mode = ir[11:9];
                d = ir[2:0];
                if (d > 3'd4 || mode == 3'b101 || mode == 3'b111) return fetchAddr;
                if (!mode[2]) begin
                    a = r[mode[1:0]];
                end else if (mode == 3'b100) begin
                    a = m[pc[7:0]];
                    pc = pc + 1'b1;
                end else begin
                    a = m[r[1][7:0]];
                end
                res = aluRef(ir[8:5], a, r[ir[4:3]], fl);
                if (d == 3'd4) begin
                    m[r[1][7:0]] = res;
                    expAddr.push_back(r[1]);
                    expData.push_back(res);
                end else if (d != 3'd0) begin
                    r[d[1:0]] = res;
                end
            end else begin
                return fetchAddr;
            end
        end
        return 16'hFFFF;  // Never halted
    endfunction

    task automatic loadProgram();
        isaPkg::word_t p [0:progLen-1];
        p = '{default: 16'h3000};
        p[0]  = iTypeWord(2'd0, 2'd1, 8'h40);             // A = 0x40
        p[1]  = iTypeWord(2'd0, 2'd2, 8'hFD);             // B = -3
        p[2]  = iTypeWord(2'd0, 2'd3, 8'h25);
        p[3]  = aTypeWord(3'b011, 4'd0, 2'd2, 3'd4);      // (A) = C + B
        p[4]  = iTypeWord(2'd0, 2'd1, 8'h01);
        p[5]  = aTypeWord(3'b011, 4'd2, 2'd2, 3'd4);
        p[6]  = iTypeWord(2'd0, 2'd1, 8'h01);
        p[7]  = aTypeWord(3'b010, 4'd1, 2'd3, 3'd4);
        p[8]  = iTypeWord(2'd0, 2'd1, 8'h01);
        p[9]  = aTypeWord(3'b010, 4'd3, 2'd3, 3'd4);
        p[10] = iTypeWord(2'd0, 2'd1, 8'h01);
        p[11] = aTypeWord(3'b011, 4'd4, 2'd2, 3'd4);
        p[12] = iTypeWord(2'd0, 2'd1, 8'h01);
        p[13] = aTypeWord(3'b000, 4'd5, 2'd3, 3'd4);      // Pass C
        p[14] = iTypeWord(2'd0, 2'd1, 8'h01);
        p[15] = iTypeWord(2'd1, 2'd3, 8'hF0);
        p[16] = iTypeWord(2'd2, 2'd2, 8'hFF);
        p[17] = iTypeWord(2'd3, 2'd3, 8'h81);
        p[18] = aTypeWord(3'b100, 4'd0, 2'd3, 3'd4);      // Next word plus C
        p[19] = 16'h1234;
        p[20] = iTypeWord(2'd0, 2'd1, 8'h01);
        p[21] = aTypeWord(3'b110, 4'd4, 2'd3, 3'd4);      // (A) ^ C
        p[22] = iTypeWord(2'd0, 2'd1, 8'h01);
        p[23] = jumpWord(15'd2);
        p[24] = aTypeWord(3'b011, 4'd6, 2'd0, 3'd4);      // Skipped
        p[25] = aTypeWord(3'b011, 4'd6, 2'd0, 3'd4);
        p[26] = flagWord(1'b1, 1'b1, 2'd1, 8'h00);        // Set carry
        p[27] = flagWord(1'b0, 1'b1, 2'd1, 8'h01);
        p[28] = aTypeWord(3'b010, 4'd6, 2'd0, 3'd4);      // Skipped
        p[29] = flagWord(1'b1, 1'b0, 2'd0, 8'h00);        // Clear zero
        p[30] = flagWord(1'b0, 1'b1, 2'd0, 8'h05);        // Not taken
        p[31] = aTypeWord(3'b001, 4'd6, 2'd0, 3'd4);
        p[32] = iTypeWord(2'd0, 2'd1, 8'h01);
        p[33] = aTypeWord(3'b011, 4'd4, 2'd3, 3'd3);      // C = 0, zero set
        p[34] = flagWord(1'b0, 1'b1, 2'd0, 8'h01);
        p[35] = aTypeWord(3'b011, 4'd6, 2'd0, 3'd4);      // Skipped
        p[36] = aTypeWord(3'b010, 4'd6, 2'd0, 3'd4);
        p[37] = jumpWord(15'd2);
        p[40] = iTypeWord(2'd0, 2'd1, 8'h01);
        p[41] = aTypeWord(3'b001, 4'd0, 2'd1, 3'd4);      // (A) = A + A
        p[42] = 16'h3000;                                 // Invalid nibble 0011
        for (int i = 0; i < 256; i++) begin
            initMem[i] = isaPkg::word_t'(i * 16'h9E37) ^ {8'hA5, 8'(i)};
        end
        for (int i = 0; i < progLen; i++) initMem[i] = p[i];
        for (int i = 0; i < 256; i++) mem[i] = initMem[i];
    endtask

    task automatic checkWrite(input isaPkg::addr_t gotAddr, input isaPkg::word_t gotData);
        if (writeCount >= expAddr.size()) begin
            failRun($sformatf("Unexpected extra write to address %h", gotAddr));
        end else if (gotAddr !== expAddr[writeCount] || gotData !== expData[writeCount]) begin
            failRun($sformatf("CHECK FAILED at %0t ns: write %0d to %h data %h, expected %h data %h",
                              $time, writeCount, gotAddr, gotData,
                              expAddr[writeCount], expData[writeCount]));
        end
        writeCount++;
    endtask

    task automatic checkHalt(input isaPkg::addr_t gotAddr);
        if (gotAddr !== expHaltAddr) begin
            failRun($sformatf("CHECK FAILED at %0t ns: halted after fetch at %h, expected %h",
                              $time, gotAddr, expHaltAddr));
        end
    endtask

    task automatic drainWrites();
        while (obsAddr.size() > 0) begin
            checkWrite(obsAddr.pop_front(), obsData.pop_front());
        end
    endtask

    initial begin
        rst = 1'b1;
        ack = 1'b0;
        datIn = '0;
        seed = 30;
        writeCount = 0;
        lastReadAddr = '0;
        loadProgram();
        expHaltAddr = runModel();
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

    // Slave with 1 to waitLimit cycles of delay
    always begin
        @(posedge clk);
        #1;
        if (!rst && stb && !ack) begin
            waitCycles = 1 + ($unsigned($random(seed)) % waitLimit);
            repeat (waitCycles - 1) @(posedge clk);
            if (waitCycles > 1) #1;
            if (we) begin
                mem[adr[7:0]] = datOut;
                obsAddr.push_back(adr);
                obsData.push_back(datOut);
            end else begin
                datIn = mem[adr[7:0]];
                lastReadAddr = adr;
            end
            ack = 1'b1;
            @(posedge clk);
            #1 ack = 1'b0;
        end
    end

    initial begin : compareProc
        @(negedge rst);
        while (!halted) begin
            @(negedge clk);
            drainWrites();
        end
        repeat (8) begin
            @(negedge clk);
            if (cyc) failRun("A bus cycle started after the core halted");
        end
        drainWrites();
        checkHalt(lastReadAddr);
        if (writeCount != expAddr.size()) begin
            failRun($sformatf("Only %0d of %0d expected writes were seen",
                              writeCount, expAddr.size()));
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

    initial begin : watchdog
        repeat (timeoutCycles) @(posedge clk);
        failRun($sformatf("Timeout after %0d cycles, the core did not halt", timeoutCycles));
    end

endmodule

`default_nettype wire

//--- sim/cpuCore_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore_properties (
    input wire logic           clk,
    input wire logic           rst,
    input wire logic           cyc,
    input wire logic           stb,
    input wire logic           we,
    input wire isaPkg::addr_t  adr,
    input wire logic           ack,
    input wire logic           halted
);

    // Both strobes end in the cycle after ack
    ackEndsCycle: assert property (@(posedge clk) disable iff (rst)
        (stb && ack) |=> (!stb && !cyc))
        else $error("stb or cyc still high after ack");

    // Address and direction held until the slave answers
    reqStable: assert property (@(posedge clk) disable iff (rst)
        (stb && !ack) |=> ($stable(adr) && $stable(we)))
        else $error("adr or we changed while waiting for ack");

    noCycHalted: assert property (@(posedge clk) disable iff (rst) halted |-> !cyc)
        else $error("bus cycle while halted");

    haltSticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else $error("halted fell without reset");

endmodule

`default_nettype wire

//--- sim/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int periodNs = 8
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(periodNs / 2.0) clk = ~clk;  // 50 percent duty

endmodule

`default_nettype wire

//--- hdl/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  wire logic           clk,
    input  wire logic           rst,
    output logic                cyc,     // Wishbone classic master
    output logic                stb,
    output logic                we,
    output isaPkg::addr_t       adr,
    output isaPkg::word_t       datOut,
    input  wire isaPkg::word_t  datIn,
    input  wire logic           ack,
    output logic                halted
);

    // Decoded instruction fields
    isaPkg::instrClass_t instrClass;
    isaPkg::aluFunc_t aluFunc;
    isaPkg::srcMode_t srcMode;
    logic [1:0] srcReg;
    isaPkg::dest_t dest;
    isaPkg::word_t immValue;
    isaPkg::word_t jumpOffset;
    logic branchTaken;

    // Sequencer strobes and bus request
    logic loadInstr, busReq, busWrite, busDone;
    logic regWrite, flagWrite, flagLoad, operandLoad;
    isaPkg::addr_t busAddr;
    isaPkg::word_t busWData;
    isaPkg::word_t busRData;
    ctrlPkg::pcSel_t pcSel;

    // Datapath state seen by the others
    isaPkg::addr_t pc;
    isaPkg::word_t regA;
    isaPkg::flags_t flags;
    isaPkg::word_t aluResult;

    instrDecoder decoder (.instrIn(busRData), .*);

    controlSequencer sequencer (.*);

    dataPath datapath (.*);

    wbMaster busMaster (.*);

endmodule

`default_nettype wire

//--- hdl/wbMaster.sv
`timescale 1ns/1ps
`default_nettype none

module wbMaster (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           busReq,    // One-cycle request
    input  wire logic           busWrite,
    input  wire isaPkg::addr_t  busAddr,
    input  wire isaPkg::word_t  busWData,
    input  wire logic           ack,
    input  wire isaPkg::word_t  datIn,
    output logic                busDone,
    output isaPkg::word_t       busRData,
    output logic                cyc,
    output logic                stb,
    output logic                we,
    output isaPkg::addr_t       adr,
    output isaPkg::word_t       datOut
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc     <= 1'b0;
            stb     <= 1'b0;
            we      <= 1'b0;
            busDone <= 1'b0;
        end else begin
            busDone <= 1'b0;
            if (busReq) begin
                cyc <= 1'b1;
                stb <= 1'b1;
                we  <= busWrite;
            end else if (stb && ack) begin  // Drop strobes after ack
                cyc     <= 1'b0;
                stb     <= 1'b0;
                we      <= 1'b0;
                busDone <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busReq) begin
            adr    <= busAddr;
            datOut <= busWData;
        end
        if (stb && ack) busRData <= datIn;
    end

endmodule

`default_nettype wire

//--- hdl/dataPath.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpuCore_cfg.svh"

module dataPath (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire isaPkg::aluFunc_t     aluFunc,
    input  wire isaPkg::srcMode_t     srcMode,   // Flag value and index on F-type
    input  wire logic [1:0]           srcReg,
    input  wire isaPkg::dest_t        dest,
    input  wire isaPkg::word_t        immValue,
    input  wire isaPkg::word_t        jumpOffset,
    input  wire isaPkg::instrClass_t  instrClass,
    input  wire ctrlPkg::pcSel_t      pcSel,
    input  wire logic                 regWrite,
    input  wire logic                 flagWrite,
    input  wire logic                 flagLoad,
    input  wire logic                 operandLoad,
    input  wire isaPkg::word_t        busRData,
    output isaPkg::addr_t             pc,
    output isaPkg::word_t             regA,
    output isaPkg::flags_t            flags,
    output isaPkg::word_t             aluResult
);

    localparam int W = `CPU_WORD_W;

    isaPkg::word_t regB;
    isaPkg::word_t regC;
    isaPkg::word_t memOperand;  // Word read in the operand state
    isaPkg::word_t aluInA;
    isaPkg::word_t aluInB;
    isaPkg::addr_t pcOffset;
    isaPkg::flags_t newFlags;
    logic [W:0] wideRes;        // Top bit is carry or borrow

    function automatic isaPkg::word_t readReg(input logic [1:0] idx, input isaPkg::word_t a,
                                              input isaPkg::word_t b, input isaPkg::word_t c);
        case (idx)
            2'd1: return a;
            2'd2: return b;
            2'd3: return c;
            default: return '0;  // Code 0 reads zero
        endcase
    endfunction

    always_comb begin
        if (instrClass == isaPkg::imm) begin
            aluInA = readReg(srcReg, regA, regB, regC);
            aluInB = immValue;
        end else begin
            aluInA = srcMode[2] ? memOperand : readReg(srcMode[1:0], regA, regB, regC);
            aluInB = readReg(srcReg, regA, regB, regC);
        end
    end

    always_comb begin
        case (aluFunc)
            isaPkg::add:   wideRes = {1'b0, aluInA} + {1'b0, aluInB};
            isaPkg::sub:   wideRes = {1'b0, aluInA} - {1'b0, aluInB};
            isaPkg::andOp: wideRes = {1'b0, aluInA & aluInB};
            isaPkg::orOp:  wideRes = {1'b0, aluInA | aluInB};
            isaPkg::xorOp: wideRes = {1'b0, aluInA ^ aluInB};
            isaPkg::passB: wideRes = {1'b0, aluInB};
            default:       wideRes = {1'b0, aluInA};
        endcase
        aluResult = wideRes[W-1:0];
        newFlags = '0;
        newFlags[isaPkg::flagZero] = (aluResult == '0);
        newFlags[isaPkg::flagNeg]  = aluResult[W-1];
        if (aluFunc == isaPkg::add) begin
            newFlags[isaPkg::flagCarry] = wideRes[W];
            newFlags[isaPkg::flagOvf] = (aluInA[W-1] == aluInB[W-1]) &&
                                        (aluResult[W-1] != aluInA[W-1]);
        end else if (aluFunc == isaPkg::sub) begin
            newFlags[isaPkg::flagCarry] = wideRes[W];  // Borrow
            newFlags[isaPkg::flagOvf] = (aluInA[W-1] != aluInB[W-1]) &&
                                        (aluResult[W-1] != aluInA[W-1]);
        end
    end

    // Branches carry an 8-bit offset, jumps a 15-bit one
    assign pcOffset = (instrClass == isaPkg::branch) ? isaPkg::addr_t'(immValue) :
                                                       isaPkg::addr_t'(jumpOffset);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regA  <= '0;
            regB  <= '0;
            regC  <= '0;
            flags <= '0;
            pc    <= `CPU_RESET_PC;
        end else begin
            if (regWrite) begin
                case (dest)
                    isaPkg::destA: regA <= aluResult;
                    isaPkg::destB: regB <= aluResult;
                    isaPkg::destC: regC <= aluResult;
                    default: ;
                endcase
            end
            if (flagWrite) begin
                flags <= newFlags;
            end else if (flagLoad) begin
                flags[srcMode[1:0]] <= srcMode[2];
            end
            case (pcSel)
                ctrlPkg::increment: pc <= pc + 1'b1;
                ctrlPkg::relative:  pc <= pc + pcOffset;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (operandLoad) memOperand <= busRData;
    end

endmodule

`default_nettype wire

//--- hdl/controlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire isaPkg::instrClass_t  instrClass,
    input  wire isaPkg::srcMode_t     srcMode,
    input  wire isaPkg::dest_t        dest,
    input  wire logic                 branchTaken,
    input  wire logic                 busDone,
    input  wire isaPkg::word_t        aluResult,
    input  wire isaPkg::word_t        regA,
    input  wire isaPkg::addr_t        pc,
    output logic                      loadInstr,
    output logic                      busReq,
    output logic                      busWrite,
    output isaPkg::addr_t             busAddr,
    output isaPkg::word_t             busWData,
    output ctrlPkg::pcSel_t           pcSel,
    output logic                      regWrite,
    output logic                      flagWrite,
    output logic                      flagLoad,
    output logic                      operandLoad,
    output logic                      halted
);

    ctrlPkg::seqState_t state;
    ctrlPkg::seqState_t nextState;
    logic busy;         // Bus access outstanding
    logic needOperand;

    assign needOperand = (instrClass == isaPkg::alu) && srcMode[2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ctrlPkg::fetch;
            busy  <= 1'b0;
        end else begin
            state <= nextState;
            if (busReq) begin
                busy <= 1'b1;
            end else if (busDone) begin
                busy <= 1'b0;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            ctrlPkg::fetch: if (busDone) nextState = ctrlPkg::operand;
            ctrlPkg::operand: begin
                if (instrClass == isaPkg::invalid) begin
                    nextState = ctrlPkg::halted;
                end else if (!needOperand || busDone) begin
                    nextState = ctrlPkg::execute;
                end
            end
            ctrlPkg::execute: begin
                if (dest == isaPkg::destMem) begin
                    nextState = ctrlPkg::store;
                end else begin
                    nextState = ctrlPkg::fetch;
                end
            end
            ctrlPkg::store: if (busDone) nextState = ctrlPkg::fetch;
            default: nextState = ctrlPkg::halted;
        endcase
    end

    always_comb begin
        loadInstr   = 1'b0;
        busReq      = 1'b0;
        busWrite    = 1'b0;
        busAddr     = pc;
        pcSel       = ctrlPkg::hold;
        regWrite    = 1'b0;
        flagWrite   = 1'b0;
        flagLoad    = 1'b0;
        operandLoad = 1'b0;
        case (state)
            ctrlPkg::fetch: begin
                busReq    = !busy;
                loadInstr = busDone;
                if (busDone) pcSel = ctrlPkg::increment;
            end
            ctrlPkg::operand: begin
                if (needOperand) begin
                    busReq      = !busy;
                    operandLoad = busDone;
                    if (srcMode == isaPkg::srcNextWord) begin
                        if (busDone) pcSel = ctrlPkg::increment;  // Skip operand word
                    end else begin
                        busAddr = isaPkg::addr_t'(regA);
                    end
                end
            end
            ctrlPkg::execute: begin
                case (instrClass)
                    isaPkg::alu, isaPkg::imm: begin
                        regWrite  = 1'b1;  // Datapath ignores memory destination
                        flagWrite = 1'b1;
                    end
                    isaPkg::jump: pcSel = ctrlPkg::relative;
                    isaPkg::flagSet: flagLoad = 1'b1;
                    isaPkg::branch: if (branchTaken) pcSel = ctrlPkg::relative;
                    default: ;
                endcase
            end
            ctrlPkg::store: begin
                busReq   = !busy;
                busWrite = 1'b1;
                busAddr  = isaPkg::addr_t'(regA);
            end
            default: ;
        endcase
    end

    assign busWData = aluResult;  // Stable from execute through store
    assign halted   = (state == ctrlPkg::halted);

endmodule

`default_nettype wire

//--- hdl/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 loadInstr,   // Fetch data valid
    input  wire isaPkg::word_t        instrIn,
    input  wire isaPkg::flags_t       flags,
    output isaPkg::instrClass_t       instrClass,
    output isaPkg::aluFunc_t          aluFunc,
    output isaPkg::srcMode_t          srcMode,
    output logic [1:0]                srcReg,
    output isaPkg::dest_t             dest,
    output isaPkg::word_t             immValue,
    output isaPkg::word_t             jumpOffset,
    output logic                      branchTaken
);

    isaPkg::word_t ir;  // Instruction register
    logic aluModeOk;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ir <= '0;
        end else if (loadInstr) begin
            ir <= instrIn;
        end
    end

    // Absolute and stack-indexed source modes are not supported
    assign aluModeOk = !ir[11] || (ir[11:9] == isaPkg::srcNextWord) ||
                       (ir[11:9] == isaPkg::srcMemA);

    always_comb begin
        instrClass = isaPkg::invalid;
        aluFunc    = isaPkg::passA;
        srcMode    = ir[11:9];
        srcReg     = ir[4:3];  // Source 2 of A-type
        dest       = isaPkg::destNone;
        casez (ir[15:12])
            4'b1???: instrClass = isaPkg::jump;
            4'b01??: begin
                if (!ir[11]) begin  // Bits 11:9 are source and destination
                    instrClass = isaPkg::imm;
                    aluFunc    = isaPkg::aluFunc_t'({2'b00, ir[13:12]});
                    srcReg     = ir[10:9];
                    dest       = ir[11:9];
                end
            end
            4'b0000: begin
                if (aluModeOk && (ir[2:0] <= isaPkg::destMem)) begin
                    instrClass = isaPkg::alu;
                    aluFunc    = isaPkg::aluFunc_t'(ir[8:5]);
                    dest       = ir[2:0];
                end
            end
            4'b0010: begin
                if (ir[11]) begin
                    instrClass = isaPkg::flagSet;
                end else begin
                    instrClass = isaPkg::branch;
                end
                srcMode = ir[10:8];  // New value and flag index
            end
            default: ;
        endcase
    end

    assign immValue   = isaPkg::word_t'($signed(ir[7:0]));
    assign jumpOffset = isaPkg::word_t'($signed(ir[14:0]));

    // Chosen flag must equal bit 10
    assign branchTaken = (instrClass == isaPkg::branch) && (flags[ir[9:8]] == ir[10]);

endmodule

`default_nettype wire

//--- hdl/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    typedef enum logic [2:0] {
        fetch   = 3'd0,  // Read instruction at PC
        operand = 3'd1,  // Decode, optional operand read
        execute = 3'd2,
        store   = 3'd3,  // Write result to (A)
        halted  = 3'd4   // Left only by reset
    } seqState_t;

    typedef enum logic [1:0] {
        hold      = 2'd0,
        increment = 2'd1,
        relative  = 2'd2   // Add sign-extended offset
    } pcSel_t;

endpackage

`default_nettype wire

//--- hdl/isaPkg.sv
`default_nettype none

`include "cpuCore_cfg.svh"

package isaPkg;

    typedef logic [`CPU_WORD_W-1:0] word_t;      // Data or instruction word
    typedef logic [`CPU_ADDR_W-1:0] addr_t;
    typedef logic [`CPU_NUM_FLAGS-1:0] flags_t;

    // Bit positions inside flags_t
    localparam int unsigned flagZero  = 0;
    localparam int unsigned flagCarry = 1;
    localparam int unsigned flagNeg   = 2;
    localparam int unsigned flagOvf   = 3;

    typedef enum logic [2:0] {
        alu     = 3'd0,  // Register ALU operation
        imm     = 3'd1,  // ALU operation with 8-bit immediate
        jump    = 3'd2,
        flagSet = 3'd3,  // Set or clear one flag
        branch  = 3'd4,  // Conditional on one flag
        invalid = 3'd5
    } instrClass_t;

    typedef enum logic [3:0] {
        add   = 4'd0,
        andOp = 4'd1,
        sub   = 4'd2,
        orOp  = 4'd3,
        xorOp = 4'd4,
        passB = 4'd5,
        passA = 4'd6   // Any code above 5 acts the same
    } aluFunc_t;

    // Codes 000 to 011 name a register, 000 reads zero
    typedef logic [2:0] srcMode_t;
    localparam srcMode_t srcNextWord = 3'b100;  // Word after the instruction
    localparam srcMode_t srcMemA     = 3'b110;  // Memory at address in A

    typedef logic [2:0] dest_t;
    localparam dest_t destNone = 3'b000;  // Result discarded
    localparam dest_t destA    = 3'b001;
    localparam dest_t destB    = 3'b010;
    localparam dest_t destC    = 3'b011;
    localparam dest_t destMem  = 3'b100;  // Memory at address in A

endpackage

`default_nettype wire

//--- hdl/cpuCore_cfg.svh
`ifndef CPU_CORE_CFG_SVH
`define CPU_CORE_CFG_SVH

// Data and instruction word width
`define CPU_WORD_W 16

// Width of the Wishbone address and of the PC
`define CPU_ADDR_W 16

// Address of the first instruction fetch
`define CPU_RESET_PC 16'h0000

// Zero, carry, negative and overflow
`define CPU_NUM_FLAGS 4

`endif
